//--- include/mcu_io_cfg.svh
`ifndef MCU_IO_CFG_SVH
`define MCU_IO_CFG_SVH

// word address, wide enough for RAM plus the I/O window
`define MCU_ADDR_WIDTH 9

// data RAM occupies 0x000 up to 0x07F
`define MCU_RAM_WORDS 128

// request queue entries, equal to the host's starting credits
`define MCU_REQ_DEPTH 4

// read responses the host can absorb before returning credits
`define MCU_RSP_CREDITS 2

`endif

//--- run_sim.sh
#!/bin/sh
# build and run the mcu_io testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module tb_mcu_io -f src.f -o tb_mcu_io
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_mcu_io > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
  echo "simulation reported failures"
  exit 1
fi

if ! grep -q "ALL TESTS PASSED" "$LOG"; then
  echo "simulation ended without a result"
  exit 1
fi

exit 0

//--- src.f
+incdir+include
src/bus_pkg.sv
src/io_pkg.sv
src/req_fifo.sv
src/bus_sequencer.sv
src/data_ram.sv
src/io_regs.sv
src/mcu_io_top.sv
tb/tb_mcu_io.sv

//--- src/bus_pkg.sv
`include "mcu_io_cfg.svh"

package bus_pkg;

  // ***************************************************************************
  // bus opcodes
  // ***************************************************************************

  typedef enum logic [1:0] {
    OP_READ       = 2'd0,
    OP_WRITE_WORD = 2'd1,
    OP_WRITE_BYTE = 2'd2
  } bus_op_e;

  // ***************************************************************************
  // request and response payloads
  // ***************************************************************************

  // one host request, 27 bits
  typedef struct packed {
    bus_op_e                    op;
    logic [`MCU_ADDR_WIDTH-1:0] addr;
    logic [15:0]                wdata;
  } bus_req_t;

  // read result with its word address, 25 bits
  typedef struct packed {
    logic [`MCU_ADDR_WIDTH-1:0] addr;
    logic [15:0]                rdata;
  } bus_rsp_t;

endpackage

//--- src/bus_sequencer.sv
`include "mcu_io_cfg.svh"

module bus_sequencer (
  input  logic              clk,
  input  logic              rst_n,
  input  bus_pkg::bus_req_t head,
  input  logic              empty,
  input  logic              rsp_credit,
  input  logic [15:0]       ram_rdata,
  input  logic [15:0]       io_rdata,
  output logic              pop,
  output bus_pkg::bus_req_t mem_req,
  output logic              ram_sel,
  output logic              io_sel,
  output logic              rsp_valid,
  output bus_pkg::bus_rsp_t rsp
);

  import bus_pkg::*;

  localparam int CRD_W = $clog2(`MCU_RSP_CREDITS + 1);

  logic [CRD_W-1:0]           rsp_crd;
  logic                       head_read;
  logic                       head_io;
  logic                       issue_read;

  // read tag, one stage behind the issue
  logic                       tag_valid;
  logic                       tag_io;
  logic [`MCU_ADDR_WIDTH-1:0] tag_addr;

  // ***************************************************************************
  // issue stage
  // ***************************************************************************

  assign head_read = (head.op == OP_READ);
  assign head_io   = (head.addr >= `MCU_ADDR_WIDTH'(`MCU_RAM_WORDS));

  // a read waits at the head until a response slot is free
  assign pop        = !empty && !(head_read && (rsp_crd == '0));
  assign issue_read = pop && head_read;

  assign mem_req = head;
  assign ram_sel = pop && !head_io;
  assign io_sel  = pop && head_io;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_crd <= CRD_W'(`MCU_RSP_CREDITS);
    end else begin
      case ({issue_read, rsp_credit})
        2'b10:   rsp_crd <= rsp_crd - 1'b1;
        2'b01:   rsp_crd <= rsp_crd + 1'b1;
        default: rsp_crd <= rsp_crd;
      endcase
    end
  end

  // ***************************************************************************
  // data stage and response register
  // ***************************************************************************

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tag_valid <= 1'b0;
      rsp_valid <= 1'b0;
    end else begin
      tag_valid <= issue_read;
      rsp_valid <= tag_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_read) begin
      tag_addr <= head.addr;
      tag_io   <= head_io;
    end
    if (tag_valid) begin
      rsp.addr  <= tag_addr;
      rsp.rdata <= tag_io ? io_rdata : ram_rdata;
    end
  end

endmodule

//--- src/data_ram.sv
`include "mcu_io_cfg.svh"

module data_ram (
  input  logic              clk,
  input  logic              sel,
  input  bus_pkg::bus_req_t mem_req,
  output logic [15:0]       rdata
);

  import bus_pkg::*;

  localparam int WORDS = `MCU_RAM_WORDS;
  localparam int IDX_W = $clog2(WORDS);

  logic [15:0]      mem [WORDS];
  logic [IDX_W-1:0] idx;

  // sequencer only selects the RAM below the I/O window
  assign idx = mem_req.addr[IDX_W-1:0];

  always_ff @(posedge clk) begin
    if (sel) begin
      case (mem_req.op)
        OP_READ: begin
          rdata <= mem[idx];
        end
        OP_WRITE_WORD: begin
          mem[idx] <= mem_req.wdata;
        end
        OP_WRITE_BYTE: begin
          // high byte keeps its old value
          mem[idx][7:0] <= mem_req.wdata[7:0];
        end
        default: begin
          rdata <= rdata;
        end
      endcase
    end
  end

endmodule

//--- src/io_pkg.sv
`include "mcu_io_cfg.svh"

package io_pkg;

  // I/O register map, just above the RAM window
  localparam logic [`MCU_ADDR_WIDTH-1:0] IO_ADDR_LED  = 'h080;
  localparam logic [`MCU_ADDR_WIDTH-1:0] IO_ADDR_LCD  = 'h081;
  localparam logic [`MCU_ADDR_WIDTH-1:0] IO_ADDR_GPIO = 'h082;

  // character LCD in 4-bit mode
  // register bits 7:4 -> db, 2 -> rs, 1 -> rw, 0 -> e
  typedef struct packed {
    logic [3:0] db;
    logic       rs;
    logic       rw;
    logic       e;
  } lcd_pins_t;

endpackage

//--- src/io_regs.sv
`include "mcu_io_cfg.svh"

module io_regs (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              sel,
  input  bus_pkg::bus_req_t mem_req,
  output logic [15:0]       rdata,
  output logic [7:0]        led,
  output io_pkg::lcd_pins_t lcd,
  output logic [7:0]        gpio
);

  import bus_pkg::*;
  import io_pkg::*;

  localparam int AW = `MCU_ADDR_WIDTH;

  logic          wen;
  logic          byt;
  logic [7:0]    led_q;
  logic [7:0]    lcd_q;
  logic [7:0]    gpio_q;
  logic [AW-1:0] addr_d;

  assign wen = sel && (mem_req.op != OP_READ);
  assign byt = (mem_req.op == OP_WRITE_BYTE);

  // ***************************************************************************
  // register writes
  // ***************************************************************************

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      led_q  <= '0;
      lcd_q  <= '0;
      gpio_q <= '0;
    end else if (wen) begin
      if (mem_req.addr == IO_ADDR_LED) begin
        // word write at the LED address also loads the LCD byte
        if (byt) begin
          led_q <= mem_req.wdata[7:0];
        end else begin
          {lcd_q, led_q} <= mem_req.wdata;
        end
      end else if (mem_req.addr == IO_ADDR_LCD) begin
        lcd_q <= mem_req.wdata[15:8];
      end else if (mem_req.addr == IO_ADDR_GPIO) begin
        gpio_q <= mem_req.wdata[7:0];
      end
    end
  end

  // ***************************************************************************
  // read mux on the address of the previous cycle
  // ***************************************************************************

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_d <= '0;
    end else begin
      addr_d <= mem_req.addr;
    end
  end

  always_comb begin
    rdata = 16'd0;
    // pairs of addresses share one 16-bit view
    if (addr_d[AW-1:1] == IO_ADDR_LED[AW-1:1]) begin
      rdata = {lcd_q, led_q};
    end else if (addr_d[AW-1:1] == IO_ADDR_GPIO[AW-1:1]) begin
      rdata = {8'd0, gpio_q};
    end
  end

  // pins are driven straight from the registers
  assign led    = led_q;
  assign gpio   = gpio_q;
  assign lcd.db = lcd_q[7:4];
  assign lcd.rs = lcd_q[2];
  assign lcd.rw = lcd_q[1];
  assign lcd.e  = lcd_q[0];

endmodule

//--- src/mcu_io_top.sv
module mcu_io_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_valid,
  input  bus_pkg::bus_req_t req,
  input  logic              rsp_credit,
  output logic              req_credit,
  output logic              rsp_valid,
  output bus_pkg::bus_rsp_t rsp,
  output logic [7:0]        led,
  output io_pkg::lcd_pins_t lcd,
  output logic [7:0]        gpio
);

  import bus_pkg::*;

  bus_req_t    q_head;
  logic        q_empty;
  logic        q_pop;
  bus_req_t    mem_req;
  logic        ram_sel;
  logic        io_sel;
  logic [15:0] ram_rdata;
  logic [15:0] io_rdata;

  // host side request queue
  req_fifo i_req_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (req_valid),
    .push_data (req),
    .pop       (q_pop),
    .head      (q_head),
    .empty     (q_empty),
    .credit    (req_credit)
  );

  bus_sequencer i_bus_sequencer (
    .clk        (clk),
    .rst_n      (rst_n),
    .head       (q_head),
    .empty      (q_empty),
    .rsp_credit (rsp_credit),
    .ram_rdata  (ram_rdata),
    .io_rdata   (io_rdata),
    .pop        (q_pop),
    .mem_req    (mem_req),
    .ram_sel    (ram_sel),
    .io_sel     (io_sel),
    .rsp_valid  (rsp_valid),
    .rsp        (rsp)
  );

  // both targets share the sequencer bus
  data_ram i_data_ram (
    .clk     (clk),
    .sel     (ram_sel),
    .mem_req (mem_req),
    .rdata   (ram_rdata)
  );

  io_regs i_io_regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .sel     (io_sel),
    .mem_req (mem_req),
    .rdata   (io_rdata),
    .led     (led),
    .lcd     (lcd),
    .gpio    (gpio)
  );

endmodule

//--- src/req_fifo.sv
`include "mcu_io_cfg.svh"

module req_fifo (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              push,
  input  bus_pkg::bus_req_t push_data,
  input  logic              pop,
  output bus_pkg::bus_req_t head,
  output logic              empty,
  output logic              credit
);

  import bus_pkg::*;

  localparam int DEPTH = `MCU_REQ_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  bus_req_t           entries [DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;

  // no full check, the host never pushes without a credit
  always_ff @(posedge clk) begin
    if (push) begin
      entries[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // one credit back per freed slot, a cycle after the pop
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit <= 1'b0;
    end else begin
      credit <= pop;
    end
  end

  assign head  = entries[rd_ptr];
  assign empty = (count == '0);

endmodule

//--- tb/tb_mcu_io.sv
`include "mcu_io_cfg.svh"

module tb_mcu_io;

  timeunit 1ns;
  timeprecision 1ps;

  import bus_pkg::*;
  import io_pkg::*;

  localparam int REQ_DEPTH   = `MCU_REQ_DEPTH;
  localparam int RSP_CREDITS = `MCU_RSP_CREDITS;
  localparam int RAM_WORDS   = `MCU_RAM_WORDS;
  localparam int MAX_CYCLES  = 4000;

  logic       clk;
  logic       rst_n;
  logic       req_valid;
  bus_req_t   req;
  logic       rsp_credit;
  logic       req_credit;
  logic       rsp_valid;
  bus_rsp_t   rsp;
  logic [7:0] led;
  lcd_pins_t  lcd;
  logic [7:0] gpio;

  // host side bookkeeping
  int          req_spent;
  int          req_returned;
  int          rsp_received;
  int          rsp_returned;
  int          cycles;
  int          value_errors;
  int          protocol_errors;
  logic        hold_rsp;
  string       test_name;
  logic [31:0] lfsr;

  // reference model
  logic [15:0] ram_s [RAM_WORDS];
  logic [7:0]  led_s;
  logic [7:0]  lcd_s;
  logic [7:0]  gpio_s;
  bus_rsp_t    exp_q [$];
  string       name_q [$];
  bus_rsp_t    got_exp;
  string       got_name;

  mcu_io_top i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req        (req),
    .rsp_credit (rsp_credit),
    .req_credit (req_credit),
    .rsp_valid  (rsp_valid),
    .rsp        (rsp),
    .led        (led),
    .lcd        (lcd),
    .gpio       (gpio)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ***************************************************************************
  // random bits and reference model
  // ***************************************************************************

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [15:0] random_bits(int n);
    logic [15:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[14:0], lfsr_bit()};
    end
    return r;
  endfunction

  function automatic logic [15:0] expected_read(logic [8:0] addr);
    if (addr[8:1] == 8'h40) begin
      return {lcd_s, led_s};
    end
    if (addr[8:1] == 8'h41) begin
      return {8'h00, gpio_s};
    end
    if (addr < 9'(RAM_WORDS)) begin
      return ram_s[addr[6:0]];
    end
    return 16'h0000;
  endfunction

  task automatic apply_write(bus_op_e op, logic [8:0] addr, logic [15:0] wdata);
    if (addr < 9'(RAM_WORDS)) begin
      if (op == OP_WRITE_WORD) begin
        ram_s[addr[6:0]] = wdata;
      end else begin
        ram_s[addr[6:0]][7:0] = wdata[7:0];
      end
    end else if (addr == IO_ADDR_LED) begin
      led_s = wdata[7:0];
      if (op == OP_WRITE_WORD) begin
        lcd_s = wdata[15:8];
      end
    end else if (addr == IO_ADDR_LCD) begin
      lcd_s = wdata[15:8];
    end else if (addr == IO_ADDR_GPIO) begin
      gpio_s = wdata[7:0];
    end
  endtask

  // ***************************************************************************
  // host tasks and checks
  // ***************************************************************************

  // called on a falling edge and returns on the next one
  task automatic send(bus_op_e op, logic [8:0] addr, logic [15:0] wdata);
    bus_rsp_t e;
    while (req_spent - req_returned >= REQ_DEPTH) begin
      @(negedge clk);
    end
    req_valid  = 1'b1;
    req.op     = op;
    req.addr   = addr;
    req.wdata  = wdata;
    req_spent++;
    if (op == OP_READ) begin
      e.addr  = addr;
      e.rdata = expected_read(addr);
      exp_q.push_back(e);
      name_q.push_back(test_name);
    end else begin
      apply_write(op, addr, wdata);
    end
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  task automatic drain();
    while (req_returned != req_spent || exp_q.size() != 0 ||
           rsp_returned != rsp_received) begin
      @(negedge clk);
    end
    @(negedge clk);
  endtask

  task automatic check_equal(string name, logic [31:0] expected, logic [31:0] actual);
    assert (expected == actual) else begin
      value_errors++;
      $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  task automatic check_pins();
    check_equal({test_name, " led"}, {24'd0, led_s}, {24'd0, led});
    check_equal({test_name, " lcd"}, {25'd0, lcd_s[7:4], lcd_s[2:0]}, {25'd0, lcd});
    check_equal({test_name, " gpio"}, {24'd0, gpio_s}, {24'd0, gpio});
  endtask

  // response credits go back one per cycle unless held
  always @(negedge clk) begin
    if (!hold_rsp && rsp_received > rsp_returned) begin
      rsp_credit = 1'b1;
      rsp_returned++;
    end else begin
      rsp_credit = 1'b0;
    end
  end

  // monitor sees the values from before each rising edge
  always @(posedge clk) begin
    if (rst_n) begin
      if (req_credit) begin
        req_returned++;
      end
      assert (req_returned <= req_spent) else begin
        protocol_errors++;
        $display("request credit arrived with no request left to free");
      end
      if (rsp_valid) begin
        rsp_received++;
        if (exp_q.size() == 0) begin
          protocol_errors++;
          $display("response arrived with no read outstanding");
        end else begin
          got_exp  = exp_q.pop_front();
          got_name = name_q.pop_front();
          check_equal({got_name, " addr"}, {23'd0, got_exp.addr}, {23'd0, rsp.addr});
          check_equal({got_name, " rdata"}, {16'd0, got_exp.rdata}, {16'd0, rsp.rdata});
        end
      end
      assert (rsp_received - rsp_returned <= RSP_CREDITS) else begin
        protocol_errors++;
        $display("more responses outstanding than response credits allow");
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // ***************************************************************************
  // test sequence
  // ***************************************************************************

  initial begin
    logic [15:0] rnd;
    logic [15:0] dat;
    bus_op_e     op;
    rst_n           = 1'b0;
    req_valid       = 1'b0;
    req             = '0;
    rsp_credit      = 1'b0;
    hold_rsp        = 1'b0;
    req_spent       = 0;
    req_returned    = 0;
    rsp_received    = 0;
    rsp_returned    = 0;
    cycles          = 0;
    value_errors    = 0;
    protocol_errors = 0;
    lfsr            = 32'hefc09814;
    led_s           = '0;
    lcd_s           = '0;
    gpio_s          = '0;
    test_name       = "reset";
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_pins();
    check_equal("reset rsp_valid", 32'd0, {31'd0, rsp_valid});
    check_equal("reset req_credit", 32'd0, {31'd0, req_credit});
    send(OP_READ, IO_ADDR_LED, 16'h0000);
    drain();

    test_name = "io write";
    send(OP_WRITE_WORD, IO_ADDR_LED, 16'ha53c);
    drain();
    check_pins();
    // LCD byte must survive this one
    send(OP_WRITE_BYTE, IO_ADDR_LED, 16'hff71);
    drain();
    check_pins();
    send(OP_WRITE_WORD, IO_ADDR_LCD, 16'h6e12);
    drain();
    check_pins();
    send(OP_WRITE_BYTE, IO_ADDR_GPIO, 16'h12c9);
    drain();
    check_pins();

    test_name = "io read";
    send(OP_READ, 9'h080, 16'h0000);
    send(OP_READ, 9'h081, 16'h0000);
    send(OP_READ, 9'h082, 16'h0000);
    send(OP_READ, 9'h083, 16'h0000);
    send(OP_READ, 9'h090, 16'h0000);
    send(OP_READ, 9'h1f0, 16'h0000);
    drain();

    test_name = "ram fill";
    for (int a = 0; a < RAM_WORDS; a++) begin
      send(OP_WRITE_WORD, 9'(a), random_bits(16));
    end
    test_name = "ram mixed writes";
    repeat (48) begin
      rnd = random_bits(1);
      op  = rnd[0] ? OP_WRITE_BYTE : OP_WRITE_WORD;
      rnd = random_bits(7);
      dat = random_bits(16);
      send(op, {2'b00, rnd[6:0]}, dat);
    end
    test_name = "ram read";
    for (int a = 0; a < RAM_WORDS; a++) begin
      send(OP_READ, 9'(a), 16'h0000);
    end
    drain();

    // back-to-back writes with each credit two cycles behind its push
    test_name = "req credits";
    repeat (8) begin
      send(OP_WRITE_BYTE, IO_ADDR_GPIO, random_bits(8));
    end
    // pop one cycle after the last push and its credit one cycle later
    repeat (2) @(negedge clk);
    check_pins();
    check_equal("req credits restored", REQ_DEPTH, REQ_DEPTH - (req_spent - req_returned));

    // two reads issue and four wait in the queue
    test_name = "rsp credits";
    hold_rsp  = 1'b1;
    repeat (6) begin
      rnd = random_bits(7);
      send(OP_READ, {2'b00, rnd[6:0]}, 16'h0000);
    end
    repeat (12) @(negedge clk);
    check_equal("rsp hold outstanding", RSP_CREDITS, rsp_received - rsp_returned);
    check_equal("rsp hold req credits", 32'd0, REQ_DEPTH - (req_spent - req_returned));
    hold_rsp = 1'b0;
    drain();

    $display("checks done: %0d value errors, %0d protocol errors",
             value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
